/* apb_dac_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dac_settings.svh"

module apb_dac_regs import dac_pkg::*; (
  input  logic                              sclk,
  input  logic                              reset,
  input  apb_req_t                          apb_req,
  output apb_rsp_t                          apb_rsp,
  output dac_start_t [`DAC_CHANNELS-1:0]    start,
  input  logic [`DAC_CHANNELS-1:0]          busy,
  input  dac_word_u [`DAC_CHANNELS-1:0]     last_word
);

  localparam int CHAN_BITS = (`DAC_CHANNELS > 1) ? $clog2(`DAC_CHANNELS) : 1;

  logic [3:0]                 chan;
  logic [7:0]                 offset;
  logic [CHAN_BITS-1:0]       chan_idx;
  logic                       chan_ok;
  logic                       is_data_wr;
  logic                       stall;
  logic                       pending;
  logic [`DAC_WORD_BITS-1:0]  rd_data;

  logic                       pready_q;
  logic                       pslverr_q;
  logic [`DAC_WORD_BITS-1:0]  prdata_q;
  logic [`DAC_CHANNELS-1:0]   start_pulse;
  dac_word_u                  wr_word;

  // Address split into channel window and register offset
  assign chan     = apb_req.paddr[11:8];
  assign offset   = apb_req.paddr[7:0];
  assign chan_idx = chan[CHAN_BITS-1:0];
  assign chan_ok  = (int'(chan) < `DAC_CHANNELS);

  assign is_data_wr = apb_req.pwrite && (offset == `DAC_REG_DATA) && chan_ok;

  // Only a data write to a channel still framing has to wait
  assign stall = is_data_wr && busy[chan_idx];

  // Transfer selected and not yet answered
  assign pending = apb_req.psel && !pready_q;

  always_comb begin
    rd_data = '0;
    if (chan_ok && !apb_req.pwrite) begin
      case (offset)
        `DAC_REG_DATA: rd_data = last_word[chan_idx].raw;
        `DAC_REG_ID:   rd_data = `DAC_ID;
        `DAC_REG_BUSY: rd_data = {{(`DAC_WORD_BITS-1){1'b0}}, busy[chan_idx]};
        // Value field only, command nibble reads as zero
        `DAC_REG_CODE: rd_data = {4'b0, last_word[chan_idx].fields.value};
        default:       rd_data = '0;
      endcase
    end
  end

  // Response is registered so pready shows up in the first access cycle
  always_ff @(posedge sclk) begin
    if (reset) begin
      pready_q    <= 1'b0;
      pslverr_q   <= 1'b0;
      prdata_q    <= '0;
      start_pulse <= '0;
    end else begin
      pready_q    <= 1'b0;
      pslverr_q   <= 1'b0;
      prdata_q    <= '0;
      start_pulse <= '0;
      if (pending && !stall) begin
        pready_q  <= 1'b1;
        pslverr_q <= !chan_ok;
        prdata_q  <= rd_data;
        // Start rides along with the completing access cycle
        if (is_data_wr) begin
          start_pulse[chan_idx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sclk) begin
    if (pending && is_data_wr && !stall) begin
      wr_word.raw <= apb_req.pwdata;
    end
  end

  // All channels share the word, only the addressed one sees start
  always_comb begin
    for (int i = 0; i < `DAC_CHANNELS; i++) begin
      start[i].start = start_pulse[i];
      start[i].word  = wr_word;
    end
  end

  assign apb_rsp.prdata  = prdata_q;
  assign apb_rsp.pready  = pready_q;
  assign apb_rsp.pslverr = pslverr_q;

  // Busy comes back from the serializers, a start must never overlap it
  assert property (@(posedge sclk) disable iff (reset)
    (start_pulse & busy) == '0)
    else $error("start issued to a busy channel");

  // Longest stall is one frame plus the handshake
  assert property (@(posedge sclk) disable iff (reset)
    (apb_req.psel && apb_req.penable && !pready_q) |-> ##[1:20] pready_q)
    else $error("pready held low beyond one frame time");

endmodule

`default_nettype wire

/* dac_bank.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dac_settings.svh"

module dac_bank import dac_pkg::*; (
  input  logic                            sclk,
  input  logic                            reset,
  input  apb_req_t                        apb_req,
  output apb_rsp_t                        apb_rsp,
  output dac_pins_t [`DAC_CHANNELS-1:0]   dac_pins
);

  // Per-channel links between register block and serializers
  dac_start_t [`DAC_CHANNELS-1:0] start;
  logic [`DAC_CHANNELS-1:0]       busy;
  dac_word_u [`DAC_CHANNELS-1:0]  last_word;

  apb_dac_regs u_regs (
    .sclk      (sclk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .start     (start),
    .busy      (busy),
    .last_word (last_word)
  );

  // Channels are independent, frames may overlap
  for (genvar ch = 0; ch < `DAC_CHANNELS; ch++) begin : g_chan
    dac_serializer u_ser (
      .sclk      (sclk),
      .reset     (reset),
      .cmd       (start[ch]),
      .busy      (busy[ch]),
      .last_word (last_word[ch]),
      .pins      (dac_pins[ch])
    );
  end

endmodule

`default_nettype wire

/* dac_pkg.sv */
`default_nettype none
`include "dac_settings.svh"

package dac_pkg;

  // APB request from the master
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [11:0]               paddr;
    logic [`DAC_WORD_BITS-1:0] pwdata;
  } apb_req_t;

  // APB response back to the master
  typedef struct packed {
    logic [`DAC_WORD_BITS-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // Pins of one converter, sync and load are active low
  typedef struct packed {
    logic nsync;
    logic nldac;
    logic din;
  } dac_pins_t;

  // Command nibble on top, conversion value below
  typedef struct packed {
    logic [3:0]                cmd;
    logic [`DAC_WORD_BITS-5:0] value;
  } dac_word_fields_t;

  typedef union packed {
    logic [`DAC_WORD_BITS-1:0] raw;
    dac_word_fields_t          fields;
  } dac_word_u;

  // One-cycle start with the word to send
  typedef struct packed {
    logic      start;
    dac_word_u word;
  } dac_start_t;

endpackage

`default_nettype wire

/* dac_serializer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dac_settings.svh"

module dac_serializer import dac_pkg::*; (
  input  logic       sclk,
  input  logic       reset,
  input  dac_start_t cmd,
  output logic       busy,
  output dac_word_u  last_word,
  output dac_pins_t  pins
);

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    LATCH
  } state_t;

  state_t                     state;
  logic [3:0]                 bit_cnt;
  logic [`DAC_WORD_BITS-1:0]  shift_reg;
  logic                       nsync_q;
  logic                       nldac_q;

  // Control FSM, frame under nsync then one load strobe
  always_ff @(posedge sclk) begin
    if (reset) begin
      state   <= IDLE;
      bit_cnt <= '0;
      nsync_q <= 1'b1;
      nldac_q <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          nldac_q <= 1'b1;
          if (cmd.start) begin
            state   <= SHIFT;
            bit_cnt <= '0;
            nsync_q <= 1'b0;
          end
        end
        SHIFT: begin
          bit_cnt <= bit_cnt + 4'd1;
          // Last bit is on din, close the frame and strobe load
          if (bit_cnt == 4'(`DAC_WORD_BITS-1)) begin
            state   <= LATCH;
            nsync_q <= 1'b1;
            nldac_q <= 1'b0;
          end
        end
        LATCH: begin
          state   <= IDLE;
          nldac_q <= 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Word capture and MSB-first shift path
  always_ff @(posedge sclk) begin
    if (reset) begin
      shift_reg <= '0;
      last_word <= '0;
    end else if (state == IDLE && cmd.start) begin
      shift_reg <= cmd.word.raw;
      last_word <= cmd.word;
    end else if (state == SHIFT) begin
      shift_reg <= {shift_reg[`DAC_WORD_BITS-2:0], 1'b0};
    end
  end

  // Busy covers the frame and the load strobe
  assign busy = (state != IDLE);

  assign pins.nsync = nsync_q;
  assign pins.nldac = nldac_q;
  assign pins.din   = shift_reg[`DAC_WORD_BITS-1];

  // One full word per frame
  assert property (@(posedge sclk) disable iff (reset)
    $fell(pins.nsync) |-> (!pins.nsync)[*`DAC_WORD_BITS] ##1 pins.nsync)
    else $error("nsync low for the wrong number of cycles");

  assert property (@(posedge sclk) disable iff (reset)
    $fell(pins.nldac) |-> pins.nsync)
    else $error("nldac fell inside a frame");

  // The register block has to hold off writes while framing
  assert property (@(posedge sclk) disable iff (reset)
    cmd.start |-> !busy)
    else $error("start received while busy");

endmodule

`default_nettype wire

/* dac_settings.svh */
`ifndef DAC_SETTINGS_SVH
`define DAC_SETTINGS_SVH

// Channels in the bank, selected by paddr[11:8]
`define DAC_CHANNELS 4

// Bits per serial frame, also the APB data width
`define DAC_WORD_BITS 16

// Constant returned by the ID register
`define DAC_ID 16'h0DAC

// Register offsets inside one channel's 256-byte window
`define DAC_REG_DATA 8'h00
`define DAC_REG_ID 8'h09
`define DAC_REG_BUSY 8'h0A
`define DAC_REG_CODE 8'h0C

`endif

/* filelist.f */
+incdir+.
dac_pkg.sv
apb_dac_regs.sv
dac_serializer.sv
dac_bank.sv
tb_dac_bank.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the DAC bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f filelist.f --top-module tb_dac_bank \
  --Mdir "$BUILD_DIR" -o tb_dac_bank
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/tb_dac_bank" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

/* tb_dac_bank.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dac_settings.svh"

module tb_dac_bank import dac_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 100;

  logic                            sclk;
  logic                            reset;
  apb_req_t                        apb_req;
  apb_rsp_t                        apb_rsp;
  dac_pins_t [`DAC_CHANNELS-1:0]   dac_pins;

  integer seed = 66;
  int     cycle = 0;
  int     pass_count = 0;
  int     error_count = 0;
  int     test_start_errors = 0;
  string  cur_test = "none";
  int     last_waits;
  int     last_done_cycle;

  // Reference model with the expected frames of each channel in send order
  logic [15:0] exp_q [`DAC_CHANNELS][$];
  logic [15:0] exp_word [`DAC_CHANNELS];
  logic        written [`DAC_CHANNELS];

  // Pin monitor state
  logic [15:0] frame_bits [`DAC_CHANNELS];
  int          bit_count [`DAC_CHANNELS];
  int          frames_seen [`DAC_CHANNELS];
  int          ldac_pulses [`DAC_CHANNELS];

  dac_bank UUT (
    .sclk     (sclk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .dac_pins (dac_pins)
  );

  initial begin
    sclk = 1'b0;
    forever #5 sclk = ~sclk;
  end

  always @(posedge sclk) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected) begin
      pass_count++;
    end else begin
      $display("Error %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond === 1'b1) begin
      pass_count++;
    end else begin
      $display("Error in %s: %s", cur_test, msg);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in %s: %s", cur_test, what);
    $display("Verification failed");
    $finish;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    if (error_count == test_start_errors) begin
      $display("Test %s: ok", cur_test);
    end else begin
      $display("Test %s: %0d errors", cur_test, error_count - test_start_errors);
    end
  endtask

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] r;
    r = next_rand();
    rand_word = r[15:0];
  endfunction

  function automatic int pick_channel();
    pick_channel = int'(next_rand() % `DAC_CHANNELS);
  endfunction

  function automatic logic [11:0] chan_addr(input int ch, input logic [7:0] off);
    chan_addr = {ch[3:0], off};
  endfunction

  function automatic logic frames_pending();
    frames_pending = 1'b0;
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      if (exp_q[ch].size() != 0 || bit_count[ch] != 0) begin
        frames_pending = 1'b1;
      end
    end
  endfunction

  // One APB transfer with setup and then access until pready
  task automatic apb_transfer(input logic write, input logic [11:0] addr,
                              input logic [15:0] wdata, output logic [15:0] rdata,
                              output logic err, output int waits);
    int guard;
    waits = 0;
    guard = 0;
    @(posedge sclk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge sclk);
    #1;
    apb_req.penable = 1'b1;
    while (!apb_rsp.pready && guard < TIMEOUT_CYCLES) begin
      @(posedge sclk);
      #1;
      waits++;
      guard++;
    end
    if (!apb_rsp.pready) begin
      report_timeout($sformatf("pready stayed low on address %h", addr));
    end else begin
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge sclk);
      #1;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
    end
  endtask

  task automatic read_reg(input int ch, input logic [7:0] off, output logic [15:0] data,
                          output logic err);
    int waits;
    apb_transfer(1'b0, chan_addr(ch, off), 16'h0000, data, err, waits);
    check_true(waits == 0, $sformatf("read of channel %0d offset %h had wait states", ch, off));
  endtask

  task automatic write_word(input int ch, input logic [15:0] word);
    logic [15:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(1'b1, chan_addr(ch, `DAC_REG_DATA), word, rdata, err, waits);
    check_value($sformatf("pslverr on write to ch%0d", ch), 16'h0000, {15'b0, err});
    // Accepted write means this word is the next frame on the channel
    exp_q[ch].push_back(word);
    exp_word[ch] = word;
    written[ch] = 1'b1;
    last_waits = waits;
    last_done_cycle = cycle;
  endtask

  task automatic wait_channels_idle();
    int guard;
    guard = 0;
    while (frames_pending() && guard < TIMEOUT_CYCLES) begin
      @(posedge sclk);
      #1;
      guard++;
    end
    if (frames_pending()) begin
      report_timeout("expected frames never appeared on the DAC pins");
    end
  endtask

  // Samples in the middle of the cycle away from the clock edge
  always @(negedge sclk) begin
    logic [15:0] expected;
    logic        ldac_due;
    if (reset) begin
      for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
        frame_bits[ch]  = '0;
        bit_count[ch]   = 0;
        frames_seen[ch] = 0;
        ldac_pulses[ch] = 0;
      end
    end else begin
      for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
        ldac_due = 1'b0;
        if (!dac_pins[ch].nsync) begin
          frame_bits[ch] = {frame_bits[ch][`DAC_WORD_BITS-2:0], dac_pins[ch].din};
          bit_count[ch]++;
          check_true(dac_pins[ch].nldac, $sformatf("nldac low inside a frame on channel %0d", ch));
        end else if (bit_count[ch] != 0) begin
          // Frame is complete once nsync has risen
          check_true(bit_count[ch] == `DAC_WORD_BITS,
                     $sformatf("frame on channel %0d was %0d bits long", ch, bit_count[ch]));
          check_true(exp_q[ch].size() != 0,
                     $sformatf("frame on channel %0d with no write behind it", ch));
          if (exp_q[ch].size() != 0) begin
            expected = exp_q[ch].pop_front();
            check_value($sformatf("din frame ch%0d", ch), expected, frame_bits[ch]);
          end
          frames_seen[ch]++;
          bit_count[ch] = 0;
          ldac_due = 1'b1;
        end
        if (!dac_pins[ch].nldac) begin
          check_true(ldac_due, $sformatf("nldac pulse not right after a frame on channel %0d", ch));
          ldac_pulses[ch]++;
        end else if (ldac_due) begin
          check_true(1'b0, $sformatf("no nldac pulse after the frame on channel %0d", ch));
        end
      end
    end
  end

  task automatic test_reset_state();
    logic [15:0] data;
    logic        err;
    begin_test("reset_state");
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      // Expect nsync and nldac high and din low
      check_value($sformatf("pins ch%0d", ch), 16'h0006, {13'b0, dac_pins[ch]});
      read_reg(ch, `DAC_REG_BUSY, data, err);
      check_value($sformatf("busy ch%0d", ch), 16'h0000, data);
      read_reg(ch, `DAC_REG_ID, data, err);
      check_value($sformatf("id ch%0d", ch), 16'h0DAC, data);
    end
    end_test();
  endtask

  task automatic test_random_frames();
    begin_test("random_frames");
    for (int i = 0; i < 12; i++) begin
      write_word(pick_channel(), rand_word());
    end
    wait_channels_idle();
    end_test();
  endtask

  task automatic test_code_readback();
    logic [15:0] data;
    logic        err;
    begin_test("code_readback");
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      if (written[ch]) begin
        read_reg(ch, `DAC_REG_CODE, data, err);
        check_value($sformatf("code ch%0d", ch), {4'h0, exp_word[ch][11:0]}, data);
      end
    end
    end_test();
  endtask

  task automatic test_busy_stall();
    int          ch;
    int          first_done;
    logic [15:0] data;
    logic        err;
    begin_test("busy_stall");
    ch = pick_channel();
    write_word(ch, rand_word());
    first_done = last_done_cycle;
    read_reg(ch, `DAC_REG_BUSY, data, err);
    check_value($sformatf("busy ch%0d during frame", ch), 16'h0001, data);
    write_word(ch, rand_word());
    check_true(last_waits > 0, "second write was not held off while the channel was busy");
    check_true(last_done_cycle - first_done >= 18,
               $sformatf("second write accepted after only %0d cycles",
                         last_done_cycle - first_done));
    wait_channels_idle();
    read_reg(ch, `DAC_REG_CODE, data, err);
    check_value($sformatf("code ch%0d", ch), {4'h0, exp_word[ch][11:0]}, data);
    end_test();
  endtask

  task automatic test_parallel_channels();
    int a;
    int b;
    begin_test("parallel_channels");
    a = pick_channel();
    b = (a + 1 + int'(next_rand() % 3)) % `DAC_CHANNELS;
    write_word(a, rand_word());
    write_word(b, rand_word());
    check_true(!dac_pins[a].nsync && !dac_pins[b].nsync,
               $sformatf("frames on channels %0d and %0d did not overlap", a, b));
    wait_channels_idle();
    end_test();
  endtask

  task automatic test_bad_access();
    int          bad_ch;
    int          ch;
    int          waits;
    logic [15:0] data;
    logic        err;
    begin_test("bad_access");
    bad_ch = 4 + int'(next_rand() % 12);
    read_reg(bad_ch, `DAC_REG_ID, data, err);
    check_value("pslverr on bad channel read", 16'h0001, {15'b0, err});
    check_value("prdata on bad channel read", 16'h0000, data);
    apb_transfer(1'b1, chan_addr(bad_ch, `DAC_REG_DATA), rand_word(), data, err, waits);
    check_value("pslverr on bad channel write", 16'h0001, {15'b0, err});
    // Upper address bits must not alias onto a real channel
    read_reg(bad_ch % `DAC_CHANNELS, `DAC_REG_BUSY, data, err);
    check_value("busy after bad channel write", 16'h0000, data);
    ch = pick_channel();
    read_reg(ch, 8'h04, data, err);
    check_value("unmapped offset read", 16'h0000, data);
    check_value("pslverr on unmapped offset", 16'h0000, {15'b0, err});
    apb_transfer(1'b1, chan_addr(ch, 8'h04), rand_word(), data, err, waits);
    read_reg(ch, `DAC_REG_BUSY, data, err);
    check_value("busy after unmapped write", 16'h0000, data);
    end_test();
  endtask

  task automatic test_strobe_count();
    begin_test("strobe_count");
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      check_value($sformatf("nldac pulses ch%0d", ch), 16'(frames_seen[ch]),
                  16'(ldac_pulses[ch]));
    end
    end_test();
  endtask

  initial begin
    apb_req = '0;
    reset   = 1'b1;
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      exp_word[ch] = '0;
      written[ch]  = 1'b0;
    end
    repeat (10) @(posedge sclk);
    #1;
    reset = 1'b0;

    test_reset_state();
    test_random_frames();
    test_code_readback();
    test_busy_stall();
    test_parallel_channels();
    test_bad_access();
    test_strobe_count();

    $display("Checks passed: %0d, errors: %0d", pass_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
